// ==== socBusPkg.sv ====
package socBusPkg;

    // Top block field of the word address
    localparam int AddrTopBits = 4;
    localparam logic [AddrTopBits-1:0] AddrTopMem = 4'd1;
    localparam logic [AddrTopBits-1:0] AddrTopIo = 4'd2;

    // Memory block slave codes
    localparam logic [3:0] AddrMemSlaveRam = 4'd1;

    // IO block slave codes
    localparam logic [16:0] AddrIoSlaveUart = 17'd0;
    localparam logic [16:0] AddrIoSlaveCounter = 17'd1;

    // Memory block view of the word address
    typedef struct packed {
        logic [AddrTopBits-1:0] top;
        logic [3:0] slave;
        logic [21:0] offset;
    } memAddr_t;

    // IO block view of the word address
    typedef struct packed {
        logic [AddrTopBits-1:0] top;
        logic [16:0] slave;
        logic [8:0] regAddr;
    } ioAddr_t;

    typedef union packed {
        memAddr_t mem;
        ioAddr_t io;
    } busAddr_u;

    typedef struct packed {
        busAddr_u address;
        logic [3:0] byteEn;
        logic read;
        logic write;
        logic [31:0] writeData;
    } dBusReq_t;

    typedef struct packed {
        logic [31:0] readData;
        logic waitRequest;
    } dBusRsp_t;

endpackage

// ==== socPeriphPkg.sv ====
package socPeriphPkg;

    localparam int RegAddrBits = 9;

    // UART registers
    localparam logic [RegAddrBits-1:0] UartRegData = 9'd0;
    localparam logic [RegAddrBits-1:0] UartRegStatus = 9'd1;

    // Counter registers
    localparam logic [RegAddrBits-1:0] CntRegCtrl = 9'd0;
    localparam logic [RegAddrBits-1:0] CntRegCount = 9'd1;
    localparam logic [RegAddrBits-1:0] CntRegCompare = 9'd2;
    localparam logic [RegAddrBits-1:0] CntRegStatus = 9'd3;

    // Counter control word
    typedef struct packed {
        logic [29:0] reserved;
        logic clear;
        logic enable;
    } cntCtrl_t;

    // UART status word
    typedef struct packed {
        logic [30:0] reserved;
        logic busy;
    } uartStatus_t;

endpackage

// ==== dataBusDecoder.sv ====
module dataBusDecoder import socBusPkg::*; (
    input logic w_SysClk,
    input logic i_reset,

    input dBusReq_t i_dBusReq,

    input dBusRsp_t i_ramRsp,
    input dBusRsp_t i_uartRsp,
    input dBusRsp_t i_cntRsp,

    output logic o_ramSel,
    output logic o_uartSel,
    output logic o_cntSel,

    output dBusRsp_t o_dBusRsp
);

    memAddr_t memView;
    ioAddr_t ioView;

    assign memView = i_dBusReq.address.mem;
    assign ioView = i_dBusReq.address.io;

    // Memory block splits after a 4-bit slave field
    assign o_ramSel = (memView.top == AddrTopMem) && (memView.slave == AddrMemSlaveRam);

    // IO block uses a 17-bit slave field
    assign o_uartSel = (ioView.top == AddrTopIo) && (ioView.slave == AddrIoSlaveUart);
    assign o_cntSel = (ioView.top == AddrTopIo) && (ioView.slave == AddrIoSlaveCounter);

    // Unselected slaves drive zero, so a plain OR merges them
    always_comb begin
        o_dBusRsp.readData = i_ramRsp.readData | i_uartRsp.readData | i_cntRsp.readData;
        o_dBusRsp.waitRequest = i_ramRsp.waitRequest
                              | i_uartRsp.waitRequest
                              | i_cntRsp.waitRequest;
    end

    selectOneHot: assert property (
        @(posedge w_SysClk) disable iff (i_reset)
        $onehot0({o_ramSel, o_uartSel, o_cntSel})
    ) else $error("dataBusDecoder: more than one slave selected");

endmodule

// ==== dataRam.sv ====
module dataRam import socBusPkg::*; #(
    parameter int RamDepth = 64
) (
    input logic w_SysClk,
    input logic i_reset,
    input logic i_sel,
    input dBusReq_t i_dBusReq,
    output dBusRsp_t o_rsp
);

    localparam int IdxBits = (RamDepth > 1) ? $clog2(RamDepth) : 1;

    logic [31:0] memArray [RamDepth];
    logic [IdxBits-1:0] wordIdx;
    logic [31:0] readWord;
    logic readPhase;

    assign wordIdx = i_dBusReq.address.mem.offset[IdxBits-1:0];

    // Byte merge under byteEn
    always_ff @(posedge w_SysClk) begin
        if (i_sel && i_dBusReq.write) begin
            for (int b = 0; b < 4; b++) begin
                if (i_dBusReq.byteEn[b]) begin
                    memArray[wordIdx][8*b +: 8] <= i_dBusReq.writeData[8*b +: 8];
                end
            end
        end
    end

    // Synchronous read port
    always_ff @(posedge w_SysClk) begin
        readWord <= memArray[wordIdx];
    end

    // High during the data cycle of a read
    always_ff @(posedge w_SysClk) begin
        if (i_reset) begin
            readPhase <= 1'b0;
        end else if (i_sel && i_dBusReq.read) begin
            readPhase <= !readPhase;
        end else begin
            readPhase <= 1'b0;
        end
    end

    always_comb begin
        o_rsp = '0;
        if (i_sel && i_dBusReq.read) begin
            o_rsp.waitRequest = !readPhase;
            o_rsp.readData = readPhase ? readWord : 32'd0;
        end
    end

    noReadWrite: assert property (
        @(posedge w_SysClk) disable iff (i_reset)
        i_sel |-> !(i_dBusReq.read && i_dBusReq.write)
    ) else $error("dataRam: read and write high together");

endmodule

// ==== cycleCounter.sv ====
module cycleCounter import socBusPkg::*, socPeriphPkg::*; (
    input logic w_SysClk,
    input logic i_reset,
    input logic i_sel,
    input dBusReq_t i_dBusReq,
    output dBusRsp_t o_rsp
);

    logic enable;
    logic [31:0] count;
    logic [31:0] compare;
    logic matchFlag;

    logic wrEn;
    logic [RegAddrBits-1:0] regAddr;
    cntCtrl_t ctrlWrite;
    cntCtrl_t ctrlRead;
    logic [31:0] rdWord;

    assign wrEn = i_sel && i_dBusReq.write;
    assign regAddr = i_dBusReq.address.io.regAddr;
    assign ctrlWrite = cntCtrl_t'(i_dBusReq.writeData);

    always_ff @(posedge w_SysClk) begin
        if (i_reset) begin
            enable <= 1'b0;
            count <= '0;
            compare <= '0;
            matchFlag <= 1'b0;
        end else begin
            if (enable) begin
                count <= count + 32'd1;
            end
            // Sticky until software clears it
            if (enable && (count == compare)) begin
                matchFlag <= 1'b1;
            end
            // Bus writes take priority
            if (wrEn) begin
                case (regAddr)
                    CntRegCtrl: begin
                        enable <= ctrlWrite.enable;
                        if (ctrlWrite.clear) begin
                            count <= '0;
                        end
                    end
                    CntRegCount: count <= i_dBusReq.writeData;
                    CntRegCompare: compare <= i_dBusReq.writeData;
                    CntRegStatus: matchFlag <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        ctrlRead = '0;
        ctrlRead.enable = enable;
        case (regAddr)
            CntRegCtrl: rdWord = ctrlRead;
            CntRegCount: rdWord = count;
            CntRegCompare: rdWord = compare;
            CntRegStatus: rdWord = {31'd0, matchFlag};
            default: rdWord = '0;
        endcase
        // Never stalls the bus
        o_rsp = '0;
        if (i_sel && i_dBusReq.read) begin
            o_rsp.readData = rdWord;
        end
    end

    holdWhileDisabled: assert property (
        @(posedge w_SysClk) disable iff (i_reset)
        (!enable && !(wrEn && (regAddr == CntRegCtrl || regAddr == CntRegCount)))
            |=> $stable(count)
    ) else $error("cycleCounter: count moved while disabled");

endmodule

// ==== uartTx.sv ====
module uartTx import socBusPkg::*, socPeriphPkg::*; #(
    parameter int UartClksPerBit = 8
) (
    input logic w_SysClk,
    input logic i_reset,
    input logic i_sel,
    input dBusReq_t i_dBusReq,
    output dBusRsp_t o_rsp,
    output logic o_uartTx
);

    localparam int TimerBits = (UartClksPerBit > 1) ? $clog2(UartClksPerBit) : 1;
    localparam logic [TimerBits-1:0] TimerLast = TimerBits'(UartClksPerBit - 1);

    logic busy;
    logic [9:0] shiftReg;
    logic [TimerBits-1:0] bitTimer;
    logic [3:0] bitIndex;

    logic [RegAddrBits-1:0] regAddr;
    logic dataWrite;
    logic startFrame;
    logic bitDone;
    uartStatus_t status;

    assign regAddr = i_dBusReq.address.io.regAddr;
    assign dataWrite = i_sel && i_dBusReq.write && (regAddr == UartRegData);
    assign startFrame = dataWrite && !busy;
    assign bitDone = (bitTimer == TimerLast);

    // Line idles high through the all-ones fill
    assign o_uartTx = shiftReg[0];

    always_ff @(posedge w_SysClk) begin
        if (i_reset) begin
            busy <= 1'b0;
            shiftReg <= '1;
            bitTimer <= '0;
            bitIndex <= '0;
        end else if (startFrame) begin
            // Stop, data LSB first, start
            shiftReg <= {1'b1, i_dBusReq.writeData[7:0], 1'b0};
            busy <= 1'b1;
            bitTimer <= '0;
            bitIndex <= '0;
        end else if (busy) begin
            if (bitDone) begin
                bitTimer <= '0;
                if (bitIndex == 4'd9) begin
                    busy <= 1'b0;
                end else begin
                    shiftReg <= {1'b1, shiftReg[9:1]};
                    bitIndex <= bitIndex + 4'd1;
                end
            end else begin
                bitTimer <= bitTimer + TimerBits'(1);
            end
        end
    end

    always_comb begin
        status = '0;
        status.busy = busy;
        o_rsp = '0;
        if (i_sel) begin
            // Hold off a DATA write until the frame ends
            o_rsp.waitRequest = dataWrite && busy;
            if (i_dBusReq.read && (regAddr == UartRegStatus)) begin
                o_rsp.readData = status;
            end
        end
    end

    idleLineHigh: assert property (
        @(posedge w_SysClk) disable iff (i_reset)
        !busy |-> o_uartTx
    ) else $error("uartTx: line low while idle");

endmodule

// ==== socTop.sv ====
module socTop import socBusPkg::*; #(
    parameter int RamDepth = 64,
    parameter int UartClksPerBit = 8
) (
    input logic w_SysClk,
    input logic i_reset,
    input dBusReq_t i_dBusReq,
    output dBusRsp_t o_dBusRsp,
    output logic o_uartTx
);

    logic ramSel;
    logic uartSel;
    logic cntSel;

    dBusRsp_t ramRsp;
    dBusRsp_t uartRsp;
    dBusRsp_t cntRsp;

    dataBusDecoder dataBusDecoder_i (
        .w_SysClk(w_SysClk),
        .i_reset(i_reset),
        .i_dBusReq(i_dBusReq),
        .i_ramRsp(ramRsp),
        .i_uartRsp(uartRsp),
        .i_cntRsp(cntRsp),
        .o_ramSel(ramSel),
        .o_uartSel(uartSel),
        .o_cntSel(cntSel),
        .o_dBusRsp(o_dBusRsp)
    );

    // Memory block
    dataRam #(
        .RamDepth(RamDepth)
    ) dataRam_i (
        .w_SysClk(w_SysClk),
        .i_reset(i_reset),
        .i_sel(ramSel),
        .i_dBusReq(i_dBusReq),
        .o_rsp(ramRsp)
    );

    // IO block
    uartTx #(
        .UartClksPerBit(UartClksPerBit)
    ) uartTx_i (
        .w_SysClk(w_SysClk),
        .i_reset(i_reset),
        .i_sel(uartSel),
        .i_dBusReq(i_dBusReq),
        .o_rsp(uartRsp),
        .o_uartTx(o_uartTx)
    );

    cycleCounter cycleCounter_i (
        .w_SysClk(w_SysClk),
        .i_reset(i_reset),
        .i_sel(cntSel),
        .i_dBusReq(i_dBusReq),
        .o_rsp(cntRsp)
    );

endmodule

// ==== tb_socTop.sv ====
module tb_socTop
    import socBusPkg::*, socPeriphPkg::*;
();

    localparam int RamDepth = 64;
    localparam int UartClksPerBit = 8;
    localparam int BusTimeout = 200;
    localparam int UartTimeout = 2000;
    localparam int FrameClks = 10 * UartClksPerBit;

    logic w_SysClk;
    logic i_reset;
    dBusReq_t busReq;
    dBusRsp_t busRsp;
    logic uartLine;

    int seed;
    int mismatchCount;
    int timeoutCount;
    int otherCount;
    logic [31:0] ramModel [RamDepth];
    logic [7:0] sentBytes [$];

    socTop #(
        .RamDepth(RamDepth),
        .UartClksPerBit(UartClksPerBit)
    ) socTop_i (
        .w_SysClk(w_SysClk),
        .i_reset(i_reset),
        .i_dBusReq(busReq),
        .o_dBusRsp(busRsp),
        .o_uartTx(uartLine)
    );

    initial begin
        w_SysClk = 1'b0;
        forever begin
            #5 w_SysClk = ~w_SysClk;
        end
    end

    function automatic logic [29:0] ramAddr(input int idx);
        return {AddrTopMem, AddrMemSlaveRam, 22'(idx)};
    endfunction

    function automatic logic [29:0] uartAddr(input logic [RegAddrBits-1:0] regAddr);
        return {AddrTopIo, AddrIoSlaveUart, regAddr};
    endfunction

    function automatic logic [29:0] cntAddr(input logic [RegAddrBits-1:0] regAddr);
        return {AddrTopIo, AddrIoSlaveCounter, regAddr};
    endfunction

    function automatic logic [31:0] ctrlWord(input logic enable, input logic clear);
        cntCtrl_t ctrl;
        ctrl = '0;
        ctrl.enable = enable;
        ctrl.clear = clear;
        return ctrl;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        mismatchCount++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic reportFailure(input string what);
        otherCount++;
        $display("error at %0t: %s", $time, what);
    endtask

    // Called just after a rising edge, returns just after the completing edge
    task automatic busTransfer(input logic isWrite, input logic [29:0] addr,
                               input logic [3:0] byteEn, input logic [31:0] wrData,
                               input int maxWait, output logic [31:0] rdData,
                               output int waitCycles);
        busReq.address = busAddr_u'(addr);
        busReq.byteEn = byteEn;
        busReq.read = !isWrite;
        busReq.write = isWrite;
        busReq.writeData = wrData;
        waitCycles = 0;
        @(negedge w_SysClk);
        while (busRsp.waitRequest && (waitCycles < maxWait)) begin
            @(negedge w_SysClk);
            waitCycles++;
        end
        if (busRsp.waitRequest) begin
            timeoutCount++;
            $display("timeout at %0t: transfer to address %h still stalled after %0d cycles",
                     $time, addr, maxWait);
        end
        rdData = busRsp.readData;
        @(posedge w_SysClk);
        #1;
        busReq = '0;
    endtask

    task automatic busWrite(input logic [29:0] addr, input logic [3:0] byteEn,
                            input logic [31:0] data);
        logic [31:0] ignored;
        int waits;
        busTransfer(1'b1, addr, byteEn, data, BusTimeout, ignored, waits);
    endtask

    task automatic busRead(input logic [29:0] addr, output logic [31:0] data);
        int waits;
        busTransfer(1'b0, addr, 4'hf, 32'd0, BusTimeout, data, waits);
    endtask

    task automatic checkRead(input logic [29:0] addr, input logic [31:0] expected,
                             input string name);
        logic [31:0] data;
        busRead(addr, data);
        if (data !== expected) begin
            reportMismatch(name, expected, data);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(posedge w_SysClk);
        #1;
    endtask

    task automatic checkResetState();
        if (uartLine !== 1'b1) begin
            reportMismatch("o_uartTx after reset", 32'd1, {31'd0, uartLine});
        end
        checkRead(uartAddr(UartRegStatus), 32'd0, "UART STATUS after reset");
        checkRead(cntAddr(CntRegCtrl), 32'd0, "counter CTRL after reset");
        checkRead(cntAddr(CntRegCount), 32'd0, "counter COUNT after reset");
        checkRead(cntAddr(CntRegCompare), 32'd0, "counter COMPARE after reset");
        checkRead(cntAddr(CntRegStatus), 32'd0, "counter STATUS after reset");
    endtask

    task automatic exerciseRam();
        logic [31:0] randWord;
        logic [31:0] data;
        logic [3:0] byteEn;
        int idx;
        // Fill every word so later reads are defined
        for (int i = 0; i < RamDepth; i++) begin
            randWord = $random(seed);
            ramModel[i] = randWord;
            busWrite(ramAddr(i), 4'hf, randWord);
        end
        for (int n = 0; n < 200; n++) begin
            randWord = $random(seed);
            data = $random(seed);
            idx = int'(randWord[5:0]);
            byteEn = randWord[11:8];
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    ramModel[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
            busWrite(ramAddr(idx), byteEn, data);
            randWord = $random(seed);
            idx = int'(randWord[5:0]);
            checkRead(ramAddr(idx), ramModel[idx], $sformatf("RAM word %0d", idx));
        end
    endtask

    task automatic probeUnmappedAddresses();
        logic [29:0] badAddr [4];
        badAddr[0] = {4'd0, 26'h0000005};
        badAddr[1] = {4'd3, 26'h0000001};
        badAddr[2] = {AddrTopMem, 4'd2, 22'd3};
        badAddr[3] = {AddrTopIo, 17'd5, 9'd1};
        for (int k = 0; k < 4; k++) begin
            checkRead(badAddr[k], 32'd0, $sformatf("unmapped readData at %h", badAddr[k]));
            busWrite(badAddr[k], 4'hf, $random(seed));
        end
        // Counter still disabled and cleared from reset
        checkRead(cntAddr(CntRegCount), 32'd0, "COUNT after unmapped writes");
        checkRead(cntAddr(CntRegCtrl), 32'd0, "CTRL after unmapped writes");
        for (int i = 0; i < RamDepth; i++) begin
            checkRead(ramAddr(i), ramModel[i], $sformatf("RAM word %0d after unmapped", i));
        end
    endtask

    task automatic counterLoadAndMatch();
        logic [31:0] randWord;
        logic [31:0] loadVal;
        logic [31:0] first;
        logic [31:0] second;
        randWord = $random(seed);
        loadVal = {4'd0, randWord[27:0]};
        busWrite(cntAddr(CntRegCount), 4'hf, loadVal);
        busRead(cntAddr(CntRegCount), first);
        if (first !== loadVal) begin
            reportMismatch("COUNT after load", loadVal, first);
        end
        busRead(cntAddr(CntRegCount), second);
        if (second !== loadVal) begin
            reportMismatch("COUNT on second read while disabled", loadVal, second);
        end
        busWrite(cntAddr(CntRegCtrl), 4'hf, ctrlWord(1'b1, 1'b0));
        idleCycles(5);
        busWrite(cntAddr(CntRegCtrl), 4'hf, ctrlWord(1'b0, 1'b0));
        busRead(cntAddr(CntRegCount), first);
        if (first <= loadVal) begin
            reportFailure($sformatf("COUNT %h did not advance past %h", first, loadVal));
        end
        busWrite(cntAddr(CntRegCtrl), 4'hf, ctrlWord(1'b0, 1'b1));
        checkRead(cntAddr(CntRegCount), 32'd0, "COUNT after clear");

        // Compare a few counts above the load value
        randWord = $random(seed);
        loadVal = {4'd0, randWord[27:0]};
        busWrite(cntAddr(CntRegCount), 4'hf, loadVal);
        busWrite(cntAddr(CntRegCompare), 4'hf, loadVal + 32'd3);
        busWrite(cntAddr(CntRegStatus), 4'hf, 32'd0);
        checkRead(cntAddr(CntRegStatus), 32'd0, "STATUS match before enable");
        busWrite(cntAddr(CntRegCtrl), 4'hf, ctrlWord(1'b1, 1'b0));
        idleCycles(20);
        busWrite(cntAddr(CntRegCtrl), 4'hf, ctrlWord(1'b0, 1'b0));
        checkRead(cntAddr(CntRegStatus), 32'd1, "STATUS match after compare");
        busWrite(cntAddr(CntRegStatus), 4'hf, 32'd0);
        checkRead(cntAddr(CntRegStatus), 32'd0, "STATUS match after clear");
    endtask

    task automatic sendUartBytes();
        logic [31:0] randWord;
        logic [31:0] ignored;
        int waits;
        for (int n = 0; n < 6; n++) begin
            randWord = $random(seed);
            sentBytes.push_back(randWord[7:0]);
            busTransfer(1'b1, uartAddr(UartRegData), 4'h1, randWord, UartTimeout,
                        ignored, waits);
            if ((n == 0) && (waits != 0)) begin
                reportFailure("first UART write stalled while the transmitter was idle");
            end
            if ((n > 0) && (waits == 0)) begin
                reportFailure($sformatf("UART write %0d completed without back-pressure", n));
            end
        end
    endtask

    // Samples the line at mid-bit, counted from the detected start edge
    task automatic receiveUartBytes(input int count);
        logic [7:0] rxByte;
        logic [7:0] expected;
        int waited;
        for (int n = 0; n < count; n++) begin
            waited = 0;
            @(negedge w_SysClk);
            while (uartLine && (waited < UartTimeout)) begin
                @(negedge w_SysClk);
                waited++;
            end
            if (uartLine) begin
                timeoutCount++;
                $display("timeout at %0t: no start bit for UART frame %0d", $time, n);
                return;
            end
            repeat (UartClksPerBit / 2) @(negedge w_SysClk);
            if (uartLine !== 1'b0) begin
                reportFailure($sformatf("UART frame %0d start bit not low at mid-bit", n));
            end
            for (int b = 0; b < 8; b++) begin
                repeat (UartClksPerBit) @(negedge w_SysClk);
                rxByte[b] = uartLine;
            end
            repeat (UartClksPerBit) @(negedge w_SysClk);
            if (uartLine !== 1'b1) begin
                reportFailure($sformatf("UART frame %0d stop bit not high at mid-bit", n));
            end
            if (sentBytes.size() == 0) begin
                reportFailure("UART frame received with no byte written");
            end else begin
                expected = sentBytes.pop_front();
                if (rxByte !== expected) begin
                    reportMismatch("o_uartTx byte", {24'd0, expected}, {24'd0, rxByte});
                end
            end
        end
    endtask

    task automatic waitLineIdle();
        int highRun;
        int waited;
        highRun = 0;
        waited = 0;
        while ((highRun < FrameClks) && (waited < UartTimeout)) begin
            @(negedge w_SysClk);
            waited++;
            highRun = uartLine ? highRun + 1 : 0;
        end
        if (highRun < FrameClks) begin
            timeoutCount++;
            $display("timeout at %0t: UART line never idle for a full frame", $time);
        end
        @(posedge w_SysClk);
        #1;
    endtask

    task automatic uartFramesAndBackPressure();
        fork
            sendUartBytes();
            receiveUartBytes(6);
        join
        waitLineIdle();
        checkRead(uartAddr(UartRegStatus), 32'd0, "UART STATUS busy after idle frame");
        if (sentBytes.size() != 0) begin
            reportFailure($sformatf("%0d written UART bytes never received", sentBytes.size()));
        end
    endtask

    initial begin
        seed = 82;
        mismatchCount = 0;
        timeoutCount = 0;
        otherCount = 0;
        busReq = '0;
        i_reset = 1'b1;
        repeat (4) @(posedge w_SysClk);
        #1;
        i_reset = 1'b0;

        checkResetState();
        exerciseRam();
        probeUnmappedAddresses();
        counterLoadAndMatch();
        uartFramesAndBackPressure();

        $display("errors: %0d mismatches, %0d timeouts, %0d other failures",
                 mismatchCount, timeoutCount, otherCount);
        if ((mismatchCount + timeoutCount + otherCount) == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Overall cycle limit
    initial begin
        repeat (100000) @(posedge w_SysClk);
        $display("error: simulation ran past its cycle limit");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== src.f ====
socBusPkg.sv
socPeriphPkg.sv
dataBusDecoder.sv
dataRam.sv
cycleCounter.sv
uartTx.sv
socTop.sv
tb_socTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f src.f --top-module tb_socTop -o sim_tb_socTop

output="$(./obj_dir/sim_tb_socTop)"
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
else
    exit 1
fi
